//--- source/divPkg.sv
/* Integer divider package
   Widths, word types, stage structs and iterator states */
`default_nettype none

package divPkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int xlen          = 32;  // Operand width
  localparam int shiftWidth    = 6;   // Holds counts 0 to 32
  localparam int maxIterations = xlen; // One quotient bit per step at most

  typedef logic [xlen-1:0]       wordT;  // Operand, quotient, remainder
  typedef logic [shiftWidth-1:0] shiftT; // Zero count, shift, step count

  //////////////////////////////////////////////////
  // Stage structs
  //////////////////////////////////////////////////

  // Preprocessing to iterator
  typedef struct packed {
    wordT  posDividend;    // Absolute dividend
    wordT  alignedDivisor; // Absolute divisor, aligned to dividend MSB
    shiftT iterations;     // Alignment plus one
    logic  dividendSign;   // Signed ops only
    logic  divisorSign;    // Signed ops only
    logic  remOp;          // REM or REMU
    logic  divisorZero;    // Divide by zero
    logic  earlyFinish;    // Dividend below divisor, or zero
    wordT  dividend;       // Original dividend for special results
  } divOperandsT;

  // Iterator to postprocessing
  typedef struct packed {
    wordT quotient;        // Unsigned quotient
    wordT remainder;       // Unsigned remainder
    logic dividendSign;
    logic divisorSign;
    logic remOp;
    logic divisorZero;
    logic earlyFinish;
    wordT dividend;        // Carried along unchanged
  } iterResultT;

  // Iterator FSM
  typedef enum logic [1:0] {
    idle,
    iterate,
    finish
  } iterStateT;

endpackage

`default_nettype wire

//--- source/leadingZeroCount.sv
/* Leading zero counter
   Priority search from the MSB, all-zero word gives 32 */
`timescale 1ns/1ps
`default_nettype none

module leadingZeroCount (
  input  divPkg::wordT  value,  // Word to scan
  output divPkg::shiftT count   // Zeros above the first one
);

  import divPkg::*;

  // Walk up from the LSB so the highest one wins
  always_comb begin
    count = shiftT'(xlen); // No ones at all
    for (int i = 0; i < xlen; i++) begin
      if (value[i]) begin
        count = shiftT'(xlen - 1 - i);
      end
    end
  end

endmodule

`default_nettype wire

//--- source/divPreproc.sv
/* Divider preprocessing: decode, absolute values, divisor alignment
   and early-case detection, registered when a division is accepted */
`timescale 1ns/1ps
`default_nettype none

module divPreproc (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,         // One-cycle strobe
  input  logic                busy,          // Divider occupied
  input  logic [2:0]          funct3,        // 100 DIV, 101 DIVU, 110 REM, 111 REMU
  input  divPkg::wordT        dividend,
  input  divPkg::wordT        divisor,
  output divPkg::divOperandsT operands,      // Held for the iterator
  output logic                operandsValid  // Pulses after an accepted start
);

  import divPkg::*;

  logic              signedOp;      // DIV or REM
  logic              remOp;         // REM or REMU
  logic              dividendSign;
  logic              divisorSign;
  wordT              posDividend;
  wordT              posDivisor;
  logic              dividendZero;
  logic              divisorZero;
  shiftT             dividendZeros; // Leading zeros of |dividend|
  shiftT             divisorZeros;  // Leading zeros of |divisor|
  logic [shiftWidth:0] zeroDiff;    // Extra bit holds the sign
  logic              earlyFinish;
  shiftT             alignShift;
  divOperandsT       nextOperands;
  logic              accept;

  //////////////////////////////////////////////////
  // Decode and absolute values
  //////////////////////////////////////////////////

  assign signedOp = ~funct3[0];
  assign remOp    = funct3[1];

  assign dividendSign = dividend[xlen-1] & signedOp; // Unsigned ops are never negative
  assign divisorSign  = divisor[xlen-1] & signedOp;

  assign posDividend = dividendSign ? -dividend : dividend;
  assign posDivisor  = divisorSign ? -divisor : divisor;

  assign dividendZero = ~(|dividend);
  assign divisorZero  = ~(|divisor);

  //////////////////////////////////////////////////
  // Alignment
  //////////////////////////////////////////////////

  leadingZeroCount dividendLzc (
    .value (posDividend),
    .count (dividendZeros)
  );

  leadingZeroCount divisorLzc (
    .value (posDivisor),
    .count (divisorZeros)
  );

  // Positive difference means the divisor can slide up under the dividend
  assign zeroDiff = {1'b0, divisorZeros} - {1'b0, dividendZeros};

  // Dividend has more leading zeros, so quotient is zero
  assign earlyFinish = zeroDiff[shiftWidth] | dividendZero;

  // No shift for cases that skip iteration
  assign alignShift = (earlyFinish | divisorZero) ? '0 : zeroDiff[shiftWidth-1:0];

  always_comb begin
    nextOperands                = '0;
    nextOperands.posDividend    = posDividend;
    nextOperands.alignedDivisor = posDivisor << alignShift; // Top one lines up with dividend
    nextOperands.iterations     = alignShift + shiftT'(1);  // One bit per shift position
    nextOperands.dividendSign   = dividendSign;
    nextOperands.divisorSign    = divisorSign;
    nextOperands.remOp          = remOp;
    nextOperands.divisorZero    = divisorZero;
    nextOperands.earlyFinish    = earlyFinish;
    nextOperands.dividend       = dividend;
  end

  //////////////////////////////////////////////////
  // Start acceptance and operand register
  //////////////////////////////////////////////////

  assign accept = start & ~busy; // Starts while busy are dropped

  always_ff @(posedge clk) begin
    if (reset) begin
      operandsValid <= 1'b0;
    end else begin
      operandsValid <= accept;
    end
  end

  // Payload only, held until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      operands <= nextOperands;
    end
  end

  // Iterator can never be asked for more than a word of quotient bits
  iterationsBound: assert property (
    @(posedge clk) disable iff (reset)
    operandsValid |-> operands.iterations <= shiftT'(maxIterations)
  ) else $error("iterations above word width");

endmodule

`default_nettype wire

//--- source/divIterator.sv
/* Radix-2 restoring division iterator
   One quotient bit per cycle, reports busy for the whole operation */
`timescale 1ns/1ps
`default_nettype none

module divIterator (
  input  logic                clk,
  input  logic                reset,
  input  divPkg::divOperandsT operands,
  input  logic                operandsValid, // Load strobe from preprocessing
  output divPkg::iterResultT  iterResult,    // Quotient, remainder and flags
  output logic                resultValid,   // High in finish
  output logic                busy
);

  import divPkg::*;

  iterStateT state;
  iterStateT nextState;
  wordT      workDivisor; // Halves every step
  shiftT     stepCount;   // Steps left
  logic      fits;        // Remainder not below divisor
  wordT      difference;

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (operandsValid) begin
          // Special cases skip the loop entirely
          nextState = (operands.earlyFinish | operands.divisorZero) ? finish : iterate;
        end
      end
      iterate: begin
        if (stepCount == shiftT'(1)) begin
          nextState = finish; // Last quotient bit this cycle
        end
      end
      finish:  nextState = idle;
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  assign resultValid = (state == finish);
  // operandsValid covers the cycle before the load
  assign busy = operandsValid | (state != idle);

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  assign fits       = (iterResult.remainder >= workDivisor);
  assign difference = iterResult.remainder - workDivisor;

  always_ff @(posedge clk) begin
    if (state == idle && operandsValid) begin
      iterResult.quotient     <= '0;
      iterResult.remainder    <= operands.posDividend; // Working remainder
      iterResult.dividendSign <= operands.dividendSign;
      iterResult.divisorSign  <= operands.divisorSign;
      iterResult.remOp        <= operands.remOp;
      iterResult.divisorZero  <= operands.divisorZero;
      iterResult.earlyFinish  <= operands.earlyFinish;
      iterResult.dividend     <= operands.dividend;
      workDivisor             <= operands.alignedDivisor;
      stepCount               <= operands.iterations;
    end else if (state == iterate) begin
      if (fits) begin
        iterResult.remainder <= difference; // Restore step only when it fits
      end
      iterResult.quotient <= {iterResult.quotient[xlen-2:0], fits};
      workDivisor         <= workDivisor >> 1;
      stepCount           <= stepCount - shiftT'(1);
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Preprocessing must hold off while an operation is in flight
  loadOnlyInIdle: assert property (
    @(posedge clk) disable iff (reset)
    operandsValid |-> state == idle
  ) else $error("operands arrived outside idle");

  // Loop exits on the last step, so the counter stays above zero
  counterNoWrap: assert property (
    @(posedge clk) disable iff (reset)
    state == iterate |-> stepCount != '0
  ) else $error("step counter wrapped");

endmodule

`default_nettype wire

//--- source/divPostproc.sv
/* Divider postprocessing: special results, sign restore,
   quotient or remainder select, registered result with done pulse */
`timescale 1ns/1ps
`default_nettype none

module divPostproc (
  input  logic               clk,
  input  logic               reset,
  input  logic               resultValid, // Iterator in finish
  input  divPkg::iterResultT iterResult,
  output divPkg::wordT       result,      // Held until the next done
  output logic               done         // One-cycle pulse
);

  import divPkg::*;

  logic negQuotient;  // Operand signs differ
  wordT quotient;
  wordT remainder;
  wordT nextResult;

  assign negQuotient = iterResult.dividendSign ^ iterResult.divisorSign;

  //////////////////////////////////////////////////
  // Special cases and sign correction
  //////////////////////////////////////////////////

  always_comb begin
    if (iterResult.divisorZero) begin
      quotient  = '1;                  // RISC-V divide by zero
      remainder = iterResult.dividend;
    end else if (iterResult.earlyFinish) begin
      quotient  = '0;
      remainder = iterResult.dividend; // Already carries its sign
    end else begin
      // Most negative over -1 wraps back to itself here
      quotient  = negQuotient ? -iterResult.quotient : iterResult.quotient;
      remainder = iterResult.dividendSign ? -iterResult.remainder : iterResult.remainder;
    end
  end

  assign nextResult = iterResult.remOp ? remainder : quotient;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      done   <= 1'b0;
    end else begin
      done <= resultValid;
      if (resultValid) begin
        result <= nextResult; // Overwrites the previous result
      end
    end
  end

endmodule

`default_nettype wire

//--- source/intDivider.sv
/* Integer divider for DIV, DIVU, REM and REMU
   Start strobe in, busy level and done pulse out */
`timescale 1ns/1ps
`default_nettype none

module intDivider (
  input  logic         clk,
  input  logic         reset,
  input  logic         start,    // Ignored while busy
  input  logic [2:0]   funct3,
  input  divPkg::wordT dividend,
  input  divPkg::wordT divisor,
  output logic         busy,
  output logic         done,
  output divPkg::wordT result
);

  import divPkg::*;

  divOperandsT operands;      // Preproc to iterator
  logic        operandsValid;
  iterResultT  iterResult;    // Iterator to postproc
  logic        resultValid;

  divPreproc preproc (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .busy          (busy),
    .funct3        (funct3),
    .dividend      (dividend),
    .divisor       (divisor),
    .operands      (operands),
    .operandsValid (operandsValid)
  );

  divIterator iterator (
    .clk           (clk),
    .reset         (reset),
    .operands      (operands),
    .operandsValid (operandsValid),
    .iterResult    (iterResult),
    .resultValid   (resultValid),
    .busy          (busy)
  );

  divPostproc postproc (
    .clk         (clk),
    .reset       (reset),
    .resultValid (resultValid),
    .iterResult  (iterResult),
    .result      (result),
    .done        (done)
  );

endmodule

`default_nettype wire

//--- dv/clockGen.sv
/* Testbench clock source
   Free-running clock with a 4 ns period */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk
);

  localparam int halfPeriod = 2; // ns

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- dv/intDividerTb.sv
/* Integer divider testbench
   Random and corner operations checked against a RISC-V M model */
`timescale 1ns/1ps
`default_nettype none

module intDividerTb;

  import divPkg::*;

  localparam int opCount        = 2000 + 2000 + 16 + 12 + 6; // Overlap runs count twice
  localparam int timeoutCycles  = opCount * 40 + 100;
  localparam int specialLatency = 3;                 // E0 to done for skipped loops
  localparam int maxLatency     = maxIterations + 3;
  localparam logic [31:0] randomSeed = 32'hd328_72d5;

  logic       clk;
  logic       reset;
  logic       start;
  logic [2:0] funct3;
  wordT       dividend;
  wordT       divisor;
  logic       busy;
  logic       done;
  wordT       result;
  int         cycleCount = 0;
  int         doneCount  = 0;
  logic       doneLast   = 1'b0;

  clockGen clockSource (.clk(clk));

  intDivider intDivider_inst (
    .clk(clk), .reset(reset), .start(start), .funct3(funct3), .dividend(dividend),
    .divisor(divisor), .busy(busy), .done(done), .result(result)
  );

  //////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic checkResult(input wordT actual, input wordT expected, input string what);
    if (actual !== expected) begin
      stopWithFailure($sformatf("Error at %0t ns: %s gave %h, expected %h",
                                $time, what, actual, expected));
    end
  endtask

  task automatic checkBusy(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      stopWithFailure($sformatf("Error at %0t ns: %s is %b, expected %b",
                                $time, what, actual, expected));
    end
  endtask

  task automatic checkCount(input int actual, input int expected, input string what);
    if (actual != expected) begin
      stopWithFailure($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                                $time, what, actual, expected));
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model and stimulus helpers
  //////////////////////////////////////////////////

  // RISC-V M rules, including divide by zero and signed overflow
  function automatic wordT expectedResult(input logic [2:0] op, input wordT a, input wordT b);
    int   sa;
    int   sb;
    logic overflow;
    wordT value;
    sa       = a;
    sb       = b;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    value    = 32'h0;
    case (op)
      3'b100: begin
        if (b == 0)        value = 32'hffff_ffff;
        else if (overflow) value = a;
        else               value = sa / sb; // Signed, truncates toward zero
      end
      3'b101:  value = (b == 0) ? 32'hffff_ffff : a / b;
      3'b110: begin
        if (b == 0)        value = a;
        else if (overflow) value = 32'h0;
        else               value = sa % sb; // Takes the dividend's sign
      end
      3'b111:  value = (b == 0) ? a : a % b;
      default: value = 32'h0;
    endcase
    return value;
  endfunction

  // Random magnitude with random leading zeros, optionally negated
  function automatic wordT randomOperand(input logic allowNegative);
    wordT        v;
    int unsigned shift;
    v     = $urandom;
    shift = $urandom_range(31, 0);
    v     = v >> shift;
    if (allowNegative && $urandom_range(1, 0) == 1) v = -v;
    return v;
  endfunction

  // Starts on a falling edge, returns at the falling edge where done is seen
  task automatic runOperation(input logic [2:0] op, input wordT a, input wordT b,
                              output wordT value, output int edges);
    checkBusy(busy, 1'b0, "busy before start");
    start    = 1'b1;
    funct3   = op;
    dividend = a;
    divisor  = b;
    @(negedge clk); // E0 took the start
    start = 1'b0;
    edges = 1;
    while (done !== 1'b1) begin
      checkBusy(busy, 1'b1, "busy while dividing");
      @(negedge clk);
      edges++;
    end
    checkBusy(busy, 1'b0, "busy with done");  // Drops on the done edge
    value = result;
  endtask

  // exactEdges of 0 means only the upper latency bound applies
  task automatic runAndCheck(input logic [2:0] op, input wordT a, input wordT b,
                             input wordT expected, input int exactEdges, input string what);
    wordT value;
    int   edges;
    runOperation(op, a, b, value, edges);
    checkResult(value, expected, what);
    if (exactEdges > 0) checkCount(edges, exactEdges, {what, " latency"});
    else if (edges > maxLatency) checkCount(edges, maxLatency, {what, " latency bound"});
  endtask

  // Long DIVU, with a REMU start thrown in while busy
  task automatic runOverlap(input int delay);
    int doneBefore;
    int edges;
    checkBusy(busy, 1'b0, "busy before overlap run");
    start    = 1'b1;
    funct3   = 3'b101;
    dividend = 32'hffff_ffff;
    divisor  = 32'd3;
    @(negedge clk);
    doneBefore = doneCount; // Previous done already counted
    edges      = 1;
    while (done !== 1'b1) begin
      checkBusy(busy, 1'b1, "busy during overlap run");
      start = (edges == delay);
      if (start) begin
        funct3   = 3'b111;
        dividend = 32'd100;
        divisor  = 32'd7; // Would give 2
      end
      @(negedge clk);
      edges++;
    end
    start = 1'b0;
    checkResult(result, 32'h5555_5555, "result after ignored start");
    repeat (40) @(negedge clk);
    checkCount(doneCount - doneBefore, 1, "done pulses in overlap run");
  endtask

  //////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////

  // Limit grows with the number of operations
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      stopWithFailure($sformatf("Timeout: done never arrived within %0d cycles", cycleCount));
    end
  end

  // done is registered, so the value read here is last cycle's
  always @(posedge clk) begin
    if (done === 1'b1) begin
      doneCount <= doneCount + 1;
      if (doneLast === 1'b1) checkCount(2, 1, "cycles with done high");
    end
    doneLast <= done;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [2:0] op;
    wordT       a;
    wordT       b;
    reset    = 1'b1;
    start    = 1'b0;
    funct3   = 3'b000;
    dividend = '0;
    divisor  = '0;
    void'($urandom(randomSeed));
    repeat (5) @(posedge clk); // Five reset edges
    @(negedge clk);
    reset = 1'b0;
    checkBusy(busy, 1'b0, "busy after reset");
    checkCount(done ? 1 : 0, 0, "done after reset");
    checkResult(result, '0, "result after reset");

    // Signed, then unsigned random operations
    for (int i = 0; i < 4000; i++) begin
      if (i < 2000) op = ($urandom_range(1, 0) == 1) ? 3'b110 : 3'b100;
      else          op = ($urandom_range(1, 0) == 1) ? 3'b111 : 3'b101;
      a = randomOperand(~op[0]);
      b = randomOperand(~op[0]);
      runAndCheck(op, a, b, expectedResult(op, a, b), (b == 0) ? specialLatency : 0,
                  $sformatf("funct3 %b on %h, %h", op, a, b));
    end

    // Divide by zero on every operation
    for (int k = 0; k < 4; k++) begin
      op = {1'b1, 2'(k)};
      for (int j = 0; j < 4; j++) begin
        case (j)
          0:       a = 32'h0;
          1:       a = 32'h1;
          2:       a = 32'h8000_0000;
          default: a = $urandom;
        endcase
        runAndCheck(op, a, 32'h0, op[1] ? a : 32'hffff_ffff, specialLatency,
                    $sformatf("funct3 %b on %h by zero", op, a));
      end
    end

    // Overflow, zero dividend, dividend below divisor
    runAndCheck(3'b100, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 0, "DIV overflow");
    runAndCheck(3'b110, 32'h8000_0000, 32'hffff_ffff, 32'h0, 0, "REM overflow");
    runAndCheck(3'b100, 32'h0, 32'd7, 32'h0, specialLatency, "DIV of zero");
    runAndCheck(3'b101, 32'h0, 32'd7, 32'h0, specialLatency, "DIVU of zero");
    runAndCheck(3'b110, 32'h0, 32'hffff_fff9, 32'h0, specialLatency, "REM of zero");
    runAndCheck(3'b111, 32'h0, 32'd7, 32'h0, specialLatency, "REMU of zero");
    runAndCheck(3'b101, 32'd3, 32'd100, 32'h0, specialLatency, "DIVU small dividend");
    runAndCheck(3'b111, 32'd3, 32'd100, 32'd3, specialLatency, "REMU small dividend");
    runAndCheck(3'b100, 32'hffff_fffd, 32'd7, 32'h0, specialLatency, "DIV small negative");
    runAndCheck(3'b110, 32'hffff_fffd, 32'd7, 32'hffff_fffd, specialLatency,
                "REM small negative");
    runAndCheck(3'b101, 32'd5, 32'd7, 32'h0, 0, "DIVU same width");
    runAndCheck(3'b111, 32'd5, 32'd7, 32'd5, 0, "REMU same width");

    // Starts while busy at early, second and late cycles
    runOverlap(1);
    runOverlap(2);
    runOverlap(15);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
source/divPkg.sv
source/leadingZeroCount.sv
source/divPreproc.sv
source/divIterator.sv
source/divPostproc.sv
source/intDivider.sv
dv/clockGen.sv
dv/intDividerTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the integer divider testbench with Verilator
set -e

cd "$(dirname "$0")"

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module intDividerTb -f tb.f \
  -Mdir "$buildDir" -o intDividerSim

# Simulation status is taken from the log, so a fatal stop does not end the script here
"./$buildDir/intDividerSim" > "$logFile" 2>&1 || true
cat "$logFile"

if grep -q "TB FAILED" "$logFile"; then
  echo "Simulation failed, see $logFile"
  exit 1
fi
if ! grep -q "TB PASSED" "$logFile"; then
  echo "Simulation ended without a result, see $logFile"
  exit 1
fi
echo "Simulation finished cleanly"
